//--- bench/dcache_mem_model.sv
`include "dcache_macros.svh"

module dcache_mem_model (
    input  logic                  clk,
    input  logic [`DC_WORD_W-1:0] i_addr,
    input  logic                  i_write,
    input  logic [`DC_WORD_W-1:0] i_wdata,
    output logic [`DC_WORD_W-1:0] o_rdata
);

    localparam int DEPTH = 1 << `DC_WORD_W;
    localparam logic [`DC_WORD_W-1:0] PATTERN = 16'h5A3C;

    logic [`DC_WORD_W-1:0] mem [DEPTH];

    // every word starts as its own address scrambled
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[16'(a)] <= 16'(a) ^ PATTERN;
        end
    end

    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr] <= i_wdata;  // write-through lands here
        end
    end

    assign o_rdata = mem[i_addr];  // combinational read

endmodule

//--- bench/dcache_properties.sv
`include "dcache_macros.svh"

module dcache_properties (
    input logic                  clk,
    input logic                  reset_n,
    input dcache_pkg::dc_state_e i_state,
    input logic                  i_busy,
    input logic                  i_done,
    input logic                  i_mem_read,
    input logic                  i_mem_write
);

    read_write_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n) !(i_mem_read && i_mem_write)
    ) else $error("o_mem_read and o_mem_write are high in the same cycle");

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n) i_done |=> !i_done
    ) else $error("o_done stayed high for more than one cycle");

    // once reset has been seen for a full cycle
    quiet_in_reset: assert property (
        @(posedge clk) (!reset_n && !$past(reset_n))
            |-> !(i_mem_read || i_mem_write || i_done || i_busy)
    ) else $error("strobe or busy high while reset_n is low");

    // write-through only after the full wait from idle
    write_after_wait: assert property (
        @(posedge clk) disable iff (!reset_n)
            i_mem_write |-> ($past(i_state) == dcache_pkg::WAIT)
                            && ($past(i_state, `DC_WRITE_WAIT) == dcache_pkg::WAIT)
                            && ($past(i_state, `DC_WRITE_WAIT + 1) == dcache_pkg::IDLE)
    ) else $error("write-through does not follow the write wait");

endmodule

bind dcache_ctrl dcache_properties u_props (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_state     (state),
    .i_busy      (o_busy),
    .i_done      (o_done),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write)
);

//--- bench/dcache_tb.sv
`include "dcache_macros.svh"

module dcache_tb;

    localparam int PERIOD  = 8;
    localparam int TIMEOUT = 20;
    localparam int NROWS   = 18;
    localparam int IDX_W   = $clog2(NROWS);

    localparam logic [1:0] OP_READ  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_RESET = 2'd2;

    // op, address, stamp, expected hit
    localparam logic [34:0] STIM [NROWS] = '{
        {OP_READ,  16'h0042, 16'd10, 1'b0},  // cold miss
        {OP_READ,  16'h0040, 16'd11, 1'b1},
        {OP_READ,  16'h0043, 16'd12, 1'b1},
        {OP_WRITE, 16'h0041, 16'd13, 1'b1},
        {OP_READ,  16'h0041, 16'd14, 1'b1},
        {OP_WRITE, 16'h0105, 16'd15, 1'b0},  // write miss, no allocate
        {OP_READ,  16'h0105, 16'd16, 1'b0},
        {OP_READ,  16'h0107, 16'd17, 1'b1},
        {OP_READ,  16'h0080, 16'd20, 1'b0},  // second way of set 0
        {OP_READ,  16'h0040, 16'd21, 1'b1},
        {OP_READ,  16'h00C1, 16'd22, 1'b0},  // 0080 is older
        {OP_READ,  16'h0042, 16'd23, 1'b1},
        {OP_READ,  16'h0082, 16'd24, 1'b0},
        {OP_READ,  16'h00C3, 16'd25, 1'b0},
        {OP_READ,  16'h0081, 16'd26, 1'b1},
        {OP_RESET, 16'h0000, 16'd0,  1'b0},
        {OP_READ,  16'h0081, 16'd30, 1'b0},
        {OP_READ,  16'h0083, 16'd31, 1'b1}
    };

    logic                  clk;
    logic                  reset_n;
    logic                  req_read;
    logic                  req_write;
    logic [`DC_WORD_W-1:0] req_addr;
    logic [`DC_WORD_W-1:0] req_wdata;
    logic [`DC_WORD_W-1:0] req_count;
    logic                  hit;
    logic [`DC_WORD_W-1:0] rdata;
    logic                  busy;
    logic                  done;
    logic [`DC_WORD_W-1:0] mem_addr;
    logic                  mem_read;
    logic                  mem_write;
    logic [`DC_WORD_W-1:0] mem_wdata;
    logic [`DC_WORD_W-1:0] mem_rdata;

    // reference cache and memory
    logic                  m_valid [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_W-1:0]  m_tag   [`DC_SETS][`DC_WAYS];
    logic [`DC_WORD_W-1:0] m_stamp [`DC_SETS][`DC_WAYS];
    logic [`DC_WORD_W-1:0] m_data  [`DC_SETS][`DC_WAYS][`DC_WORDS];
    logic [`DC_WORD_W-1:0] shadow  [logic [`DC_WORD_W-1:0]];

    logic [15:0]           lfsr;
    int                    errors;
    int                    checks;
    int                    tests_failed;

    dcache_top UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_read      (req_read),
        .i_write     (req_write),
        .i_addr      (req_addr),
        .i_wdata     (req_wdata),
        .i_count     (req_count),
        .o_hit       (hit),
        .o_rdata     (rdata),
        .o_busy      (busy),
        .o_done      (done),
        .o_mem_addr  (mem_addr),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    dcache_mem_model u_mem (
        .clk     (clk),
        .i_addr  (mem_addr),
        .i_write (mem_write),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_word(output logic [15:0] w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w    = {w[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [15:0] mem_value(input logic [15:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 16'h5A3C;
    endfunction

    function automatic string op_name(input logic [1:0] op);
        case (op)
            OP_READ:  return "read ";
            OP_WRITE: return "write";
            default:  return "reset";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < `DC_SETS; s++) begin
            m_valid[1'(s)][1'b0] = 1'b0;
            m_valid[1'(s)][1'b1] = 1'b0;
        end
    endtask

    task automatic model_lookup(input dcache_pkg::dc_addr_u a, output logic found,
                                output logic way);
        logic m0;
        logic m1;
        m0    = m_valid[a.fields.index][1'b0] && (m_tag[a.fields.index][1'b0] == a.fields.tag);
        m1    = m_valid[a.fields.index][1'b1] && (m_tag[a.fields.index][1'b1] == a.fields.tag);
        found = m0 || m1;
        way   = !m0;
    endtask

    // invalid way 0, then invalid way 1, then the older stamp
    task automatic model_fill(input dcache_pkg::dc_addr_u a, input logic [15:0] stamp);
        dcache_pkg::dc_addr_u b;
        logic                 s;
        logic                 v;
        s = a.fields.index;
        if (!m_valid[s][1'b0]) begin
            v = 1'b0;
        end else if (!m_valid[s][1'b1]) begin
            v = 1'b1;
        end else begin
            v = !(m_stamp[s][1'b0] < m_stamp[s][1'b1]);  // tie evicts way 1
        end
        b = a;
        for (int i = 0; i < `DC_WORDS; i++) begin
            b.fields.offset    = 2'(i);
            m_data[s][v][2'(i)] = mem_value(b.word);
        end
        m_valid[s][v] = 1'b1;
        m_tag[s][v]   = a.fields.tag;
        m_stamp[s][v] = stamp;
    endtask

    task automatic run_access(input logic is_write, input logic [15:0] addr,
                              input logic [15:0] stamp, input logic exp_hit);
        dcache_pkg::dc_addr_u a;
        dcache_pkg::dc_addr_u blk;
        logic                 found;
        logic                 way;
        logic                 seen_done;
        logic [15:0]          data;
        int                   n_busy;
        int                   n_reads;
        int                   exp_busy;
        int                   done_at;
        int                   cycles;
        a.word  = addr;
        data    = '0;
        done_at = is_write ? `DC_WRITE_WAIT + 1 : `DC_WORDS + 1;
        if (is_write) begin
            random_word(data);
        end
        model_lookup(a, found, way);
        check_value("model hit", 16'(found), 16'(exp_hit));
        @(negedge clk);
        req_read  = !is_write;
        req_write = is_write;
        req_addr  = addr;
        req_wdata = data;
        req_count = stamp;
        #(PERIOD / 4);
        check_value("o_hit", 16'(hit), 16'(exp_hit));
        if (found && !is_write) begin
            check_value("o_rdata", rdata, m_data[a.fields.index][way][a.fields.offset]);
        end
        if (found) begin
            m_stamp[a.fields.index][way] = stamp;
            if (is_write) begin
                m_data[a.fields.index][way][a.fields.offset] = data;
            end
        end
        @(negedge clk);
        req_read  = 1'b0;
        req_write = 1'b0;
        #(PERIOD / 4);
        if (found && !is_write) begin
            check_value("o_mem_read", 16'(mem_read), 16'h0);
        end
        n_busy    = 0;
        n_reads   = 0;
        seen_done = 1'b0;
        for (cycles = 0; busy && cycles < TIMEOUT; cycles++) begin
            n_busy++;
            // strobe timing counted from the accepting edge
            check_value("o_mem_read", 16'(mem_read), 16'(!is_write && n_busy <= `DC_WORDS));
            check_value("o_mem_write", 16'(mem_write), 16'(is_write && n_busy == done_at));
            check_value("o_done", 16'(done), 16'(n_busy == done_at));
            if (mem_read) begin
                blk               = a;
                blk.fields.offset = 2'(n_reads);  // block walked in order
                check_value("o_mem_addr", mem_addr, blk.word);
                n_reads++;
            end
            if (done && is_write) begin
                check_value("o_mem_addr", mem_addr, addr);
                check_value("o_mem_wdata", mem_wdata, data);
            end else if (done) begin
                check_value("o_hit", 16'(hit), 16'h0);
                check_value("o_rdata", rdata, mem_value(addr));
            end
            seen_done = seen_done | done;
            @(negedge clk);
            #(PERIOD / 4);
        end
        if (busy) begin
            $display("timeout: cache still busy after %0d cycles", TIMEOUT);
            errors++;
        end
        exp_busy = is_write ? `DC_WRITE_WAIT + 1 : (found ? 0 : `DC_WORDS + 2);
        check_value("o_busy cycles", 16'(n_busy), 16'(exp_busy));
        check_value("o_mem_read cycles", 16'(n_reads), (is_write || found) ? 16'h0 : 16'h4);
        if (exp_busy != 0 && !seen_done) begin
            $display("o_done never pulsed during the access to %h", addr);
            errors++;
        end
        if (is_write) begin
            shadow[addr] = data;
        end else if (!found) begin
            model_fill(a, stamp);
        end
    endtask

    task automatic do_reset();
        @(negedge clk);
        reset_n = 1'b0;
        repeat (2) @(negedge clk);
        #(PERIOD / 4);
        check_value("o_busy", 16'(busy), 16'h0);
        check_value("o_done", 16'(done), 16'h0);
        check_value("o_mem_read", 16'(mem_read), 16'h0);
        check_value("o_mem_write", 16'(mem_write), 16'h0);
        @(negedge clk);
        reset_n = 1'b1;
        clear_model();
    endtask

    initial begin
        logic [34:0] row;
        int          errs_before;
        reset_n      = 1'b0;
        req_read     = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_count    = '0;
        lfsr         = 16'd28;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        clear_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        for (int r = 0; r < NROWS; r++) begin
            row         = STIM[IDX_W'(r)];
            errs_before = errors;
            if (row[34:33] == OP_RESET) begin
                do_reset();
            end else begin
                run_access(row[34:33] == OP_WRITE, row[32:17], row[16:1], row[0]);
            end
            if (errors == errs_before) begin
                $display("test %0d %s %h: ok", r, op_name(row[34:33]), row[32:17]);
            end else begin
                tests_failed++;
                $display("test %0d %s %h: FAILED", r, op_name(row[34:33]), row[32:17]);
            end
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NROWS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

//--- rtl/dcache_ctrl.sv
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    i_read,
    input  logic                    i_write,
    input  dcache_pkg::dc_addr_u    i_addr,
    input  logic [`DC_WORD_W-1:0]   i_wdata,
    input  logic [`DC_WORD_W-1:0]   i_count,
    input  logic                    i_hit,
    input  logic [`DC_WORD_W-1:0]   i_hit_word,
    input  logic [`DC_WORD_W-1:0]   i_mem_rdata,
    output dcache_pkg::dc_addr_u    o_lookup_addr,
    output logic                    o_touch,
    output logic                    o_write_hit,
    output logic [`DC_WORD_W-1:0]   o_stamp,
    output logic [`DC_WORD_W-1:0]   o_wdata,
    output logic                    o_fill,
    output logic [`DC_WORD_W-1:0]   o_fill_words [`DC_WORDS],
    output logic [`DC_WORD_W-1:0]   o_fill_stamp,
    output logic [`DC_WORD_W-1:0]   o_rdata,
    output logic                    o_busy,
    output logic                    o_done,
    output logic [`DC_WORD_W-1:0]   o_mem_addr,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic [`DC_WORD_W-1:0]   o_mem_wdata
);

    localparam int CNT_W = $clog2(`DC_WRITE_WAIT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DC_WRITE_WAIT - 1);

    dcache_pkg::dc_state_e   state;
    dcache_pkg::dc_addr_u    req_addr;
    dcache_pkg::dc_addr_u    block_addr;
    logic [`DC_WORD_W-1:0]   req_wdata;
    logic [`DC_WORD_W-1:0]   req_stamp;
    logic [`DC_WORD_W-1:0]   fill_buf [`DC_WORDS];
    logic [`DC_WORD_W-1:0]   miss_word;
    logic [CNT_W-1:0]        wait_cnt;
    logic [`DC_OFFSET_W-1:0] fetch_off;
    logic                    idle;

    assign idle = (state == dcache_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= dcache_pkg::IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    wait_cnt <= '0;
                    if (i_read) begin
                        if (!i_hit) begin
                            state <= dcache_pkg::FETCH0;
                        end
                    end else if (i_write) begin
                        state <= dcache_pkg::WAIT;  // hit or miss, both write through
                    end
                end
                dcache_pkg::FETCH0: state <= dcache_pkg::FETCH1;
                dcache_pkg::FETCH1: state <= dcache_pkg::FETCH2;
                dcache_pkg::FETCH2: state <= dcache_pkg::FETCH3;
                dcache_pkg::FETCH3: state <= dcache_pkg::DONE;
                dcache_pkg::DONE:   state <= dcache_pkg::FILL;
                dcache_pkg::FILL:   state <= dcache_pkg::IDLE;
                dcache_pkg::WAIT: begin
                    wait_cnt <= wait_cnt + CNT_W'(1);
                    if (wait_cnt == CNT_LAST) begin
                        state <= dcache_pkg::WRITE;
                    end
                end
                dcache_pkg::WRITE:  state <= dcache_pkg::IDLE;
                default:            state <= dcache_pkg::IDLE;
            endcase
        end
    end

    // request latch and refill buffer
    always_ff @(posedge clk) begin
        if (idle && (i_read || i_write)) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
            req_stamp <= i_count;
        end
        if (o_mem_read) begin
            fill_buf[fetch_off] <= i_mem_rdata;
        end
        if (state == dcache_pkg::FETCH3) begin
            // last word is still on the bus
            miss_word <= (req_addr.fields.offset == fetch_off) ? i_mem_rdata
                                                                : fill_buf[req_addr.fields.offset];
        end
    end

    always_comb begin
        o_mem_read = 1'b1;
        case (state)
            dcache_pkg::FETCH0: fetch_off = `DC_OFFSET_W'(0);
            dcache_pkg::FETCH1: fetch_off = `DC_OFFSET_W'(1);
            dcache_pkg::FETCH2: fetch_off = `DC_OFFSET_W'(2);
            dcache_pkg::FETCH3: fetch_off = `DC_OFFSET_W'(3);
            default: begin
                fetch_off  = '0;
                o_mem_read = 1'b0;
            end
        endcase
    end

    always_comb begin
        block_addr              = req_addr;
        block_addr.fields.offset = fetch_off;
    end

    assign o_mem_addr    = o_mem_read ? block_addr.word : req_addr.word;
    assign o_mem_write   = (state == dcache_pkg::WRITE);
    assign o_mem_wdata   = req_wdata;

    assign o_lookup_addr = idle ? i_addr : req_addr;
    assign o_touch       = idle && i_read && i_hit;
    assign o_write_hit   = idle && !i_read && i_write && i_hit;
    assign o_stamp       = i_count;
    assign o_wdata       = i_wdata;

    assign o_fill        = (state == dcache_pkg::FILL);
    assign o_fill_words  = fill_buf;
    assign o_fill_stamp  = req_stamp;

    assign o_rdata       = i_hit ? i_hit_word : miss_word;
    assign o_busy        = !idle;
    assign o_done        = (state == dcache_pkg::DONE) || o_mem_write;

endmodule

//--- rtl/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// data and address width
`define DC_WORD_W 16

// address split: tag | index | offset
`define DC_TAG_W 13
`define DC_OFFSET_W 2

// geometry
`define DC_WORDS 4
`define DC_SETS 2
`define DC_WAYS 2

// idle cycles before the write-through strobe
`define DC_WRITE_WAIT 4

`endif

//--- rtl/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    // one address word, seen raw or split into its cache fields
    typedef union packed {
        logic [`DC_WORD_W-1:0] word;
        struct packed {
            logic [`DC_TAG_W-1:0]          tag;
            logic [$clog2(`DC_SETS)-1:0]   index;
            logic [`DC_OFFSET_W-1:0]       offset;
        } fields;
    } dc_addr_u;

    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        FETCH0 = 4'd1,
        FETCH1 = 4'd2,
        FETCH2 = 4'd3,
        FETCH3 = 4'd4,
        DONE   = 4'd5,
        FILL   = 4'd6,
        WAIT   = 4'd9,
        WRITE  = 4'd13
    } dc_state_e;

endpackage

//--- rtl/dcache_store.sv
`include "dcache_macros.svh"

module dcache_store (
    input  logic                    clk,
    input  logic                    reset_n,
    input  dcache_pkg::dc_addr_u    i_lookup_addr,
    output logic                    o_hit,
    output logic [`DC_WORD_W-1:0]   o_hit_word,
    input  logic                    i_touch,
    input  logic                    i_write_hit,
    input  logic [`DC_WORD_W-1:0]   i_wdata,
    input  logic [`DC_WORD_W-1:0]   i_stamp,
    input  logic                    i_fill,
    input  logic [`DC_WORD_W-1:0]   i_fill_words [`DC_WORDS],
    input  logic [`DC_WORD_W-1:0]   i_fill_stamp
);

    localparam int IDX_W = $clog2(`DC_SETS);

    logic                    valid_q [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_W-1:0]    tag_q   [`DC_SETS][`DC_WAYS];
    logic [`DC_WORD_W-1:0]   stamp_q [`DC_SETS][`DC_WAYS];
    logic [`DC_WORD_W-1:0]   data_q  [`DC_SETS][`DC_WAYS][`DC_WORDS];

    logic [IDX_W-1:0]        idx;
    logic [`DC_OFFSET_W-1:0] off;
    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_WAYS-1:0]     way_hit;
    logic                    hit_way;
    logic                    victim;

    assign idx = i_lookup_addr.fields.index;
    assign off = i_lookup_addr.fields.offset;
    assign tag = i_lookup_addr.fields.tag;

    // tag compare against every way of the indexed set
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
        end
    end

    assign o_hit      = |way_hit;
    assign hit_way    = !way_hit[0];  // way 0 wins
    assign o_hit_word = data_q[idx][hit_way][off];

    // replacement choice
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim = 1'b1;
        end else begin
            // least recently used, tie goes to way 1
            victim = (stamp_q[idx][0] < stamp_q[idx][1]) ? 1'b0 : 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                end
            end
        end else if (i_fill) begin
            valid_q[idx][victim] <= 1'b1;
        end
    end

    // tag, stamp and data
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[idx][victim]   <= tag;
            stamp_q[idx][victim] <= i_fill_stamp;
            for (int i = 0; i < `DC_WORDS; i++) begin
                data_q[idx][victim][i] <= i_fill_words[i];
            end
        end else if (i_touch || i_write_hit) begin
            stamp_q[idx][hit_way] <= i_stamp;
            if (i_write_hit) begin
                data_q[idx][hit_way][off] <= i_wdata;  // word update on write hit
            end
        end
    end

endmodule

//--- rtl/dcache_top.sv
`include "dcache_macros.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    i_read,
    input  logic                    i_write,
    input  logic [`DC_WORD_W-1:0]   i_addr,
    input  logic [`DC_WORD_W-1:0]   i_wdata,
    input  logic [`DC_WORD_W-1:0]   i_count,
    output logic                    o_hit,
    output logic [`DC_WORD_W-1:0]   o_rdata,
    output logic                    o_busy,
    output logic                    o_done,
    output logic [`DC_WORD_W-1:0]   o_mem_addr,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic [`DC_WORD_W-1:0]   o_mem_wdata,
    input  logic [`DC_WORD_W-1:0]   i_mem_rdata
);

    dcache_pkg::dc_addr_u  lookup_addr;
    logic [`DC_WORD_W-1:0] hit_word;
    logic                  touch;
    logic                  write_hit;
    logic [`DC_WORD_W-1:0] stamp;
    logic [`DC_WORD_W-1:0] wdata;
    logic                  fill;
    logic [`DC_WORD_W-1:0] fill_words [`DC_WORDS];
    logic [`DC_WORD_W-1:0] fill_stamp;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_count       (i_count),
        .i_hit         (o_hit),
        .i_hit_word    (hit_word),
        .i_mem_rdata   (i_mem_rdata),
        .o_lookup_addr (lookup_addr),
        .o_touch       (touch),
        .o_write_hit   (write_hit),
        .o_stamp       (stamp),
        .o_wdata       (wdata),
        .o_fill        (fill),
        .o_fill_words  (fill_words),
        .o_fill_stamp  (fill_stamp),
        .o_rdata       (o_rdata),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_mem_addr    (o_mem_addr),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_wdata   (o_mem_wdata)
    );

    dcache_store u_store (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_lookup_addr (lookup_addr),
        .o_hit         (o_hit),
        .o_hit_word    (hit_word),
        .i_touch       (touch),
        .i_write_hit   (write_hit),
        .i_wdata       (wdata),
        .i_stamp       (stamp),
        .i_fill        (fill),
        .i_fill_words  (fill_words),
        .i_fill_stamp  (fill_stamp)
    );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dcache_tb -f project.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
